//--- project.f
source/ps2_pkg.sv
source/scan_if.sv
source/ps2_frame_rx.sv
source/ps2_idle_timer.sv
source/scan_fifo.sv
source/key_decode_fsm.sv
source/ps2_keyboard_top.sv
tb/ps2_keyboard_monitor.sv
tb/ps2_keyboard_chk.sv
tb/tb_ps2_keyboard.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ps2_keyboard \
    -f project.f -o sim_ps2_keyboard \
    && ./obj_dir/sim_ps2_keyboard +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "All checks passed" \
    && echo "simulation PASSED" || { echo "simulation FAILED"; exit 1; }

//--- source/key_decode_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module key_decode_fsm
    import ps2_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic key_hold,
    scan_if.dec       q,
    output logic [7:0] key_ascii,
    output logic      key_valid
);

    localparam logic [1:0] ST_MAKE  = 2'd0;
    localparam logic [1:0] ST_BREAK = 2'd1;
    localparam logic [1:0] ST_EXT   = 2'd2;

    logic [1:0] state;
    logic       shift_on;
    logic       is_shift;
    logic [8:0] xlat;           // {hit, ascii}

    // scan set 2 make code to ascii, bit 8 flags a translatable key
    function automatic logic [8:0] to_ascii(input scan_code_t sc, input logic shift);
        logic [7:0] ch;
        logic       letter;
        logic       hit;
        ch     = 8'h00;
        letter = 1'b1;
        hit    = 1'b1;
        case (sc)
            8'h1c: ch = "a";
            8'h32: ch = "b";
            8'h21: ch = "c";
            8'h23: ch = "d";
            8'h24: ch = "e";
            8'h2b: ch = "f";
            8'h34: ch = "g";
            8'h33: ch = "h";
            8'h43: ch = "i";
            8'h3b: ch = "j";
            8'h42: ch = "k";
            8'h4b: ch = "l";
            8'h3a: ch = "m";
            8'h31: ch = "n";
            8'h44: ch = "o";
            8'h4d: ch = "p";
            8'h15: ch = "q";
            8'h2d: ch = "r";
            8'h1b: ch = "s";
            8'h2c: ch = "t";
            8'h3c: ch = "u";
            8'h2a: ch = "v";
            8'h1d: ch = "w";
            8'h22: ch = "x";
            8'h35: ch = "y";
            8'h1a: ch = "z";
            default:
            begin
                letter = 1'b0;
                case (sc)
                    8'h45: ch = "0";
                    8'h16: ch = "1";
                    8'h1e: ch = "2";
                    8'h26: ch = "3";
                    8'h25: ch = "4";
                    8'h2e: ch = "5";
                    8'h36: ch = "6";
                    8'h3d: ch = "7";
                    8'h3e: ch = "8";
                    8'h46: ch = "9";
                    default: hit = 1'b0;
                endcase
            end
        endcase
        if (letter && shift)
            ch = ch - 8'h20;    // upper case
        return {hit, ch};
    endfunction

    assign q.pop    = q.avail && !key_hold;
    assign is_shift = (q.code == SC_LSHIFT) || (q.code == SC_RSHIFT);
    assign xlat     = to_ascii(q.code, shift_on);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ST_MAKE;
            shift_on  <= 1'b0;
            key_valid <= 1'b0;
        end
        else
        begin
            key_valid <= 1'b0;
            if (q.pop)
            begin
                case (state)
                    ST_MAKE:
                    begin
                        if (q.code == SC_BREAK)
                            state <= ST_BREAK;
                        else if (q.code == SC_EXT)
                            state <= ST_EXT;
                        else if (is_shift)
                            shift_on <= 1'b1;
                        else
                            key_valid <= xlat[8];
                    end
                    ST_BREAK:
                    begin
                        if (is_shift)
                            shift_on <= 1'b0;   // either shift released
                        state <= ST_MAKE;
                    end
                    ST_EXT:
                    begin
                        // extended key dropped, its release too
                        state <= (q.code == SC_BREAK) ? ST_BREAK : ST_MAKE;
                    end
                    default: state <= ST_MAKE;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (q.pop && state == ST_MAKE && xlat[8])
            key_ascii <= xlat[7:0];
    end

endmodule

`default_nettype wire

//--- source/ps2_frame_rx.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic ps2_clk,
    input  wire logic ps2_data,
    input  wire logic stall,
    output logic      edge_seen,
    output logic      in_frame,
    output scan_code_t code,
    output logic      code_wr,
    output logic      frame_err
);

    logic [2:0] clk_sync;       // two sync stages plus edge history
    logic [1:0] data_sync;
    logic [3:0] bit_cnt;
    ps2_frame_u shift_q;
    ps2_frame_u frame_nxt;
    logic       frame_ok;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            clk_sync  <= 3'b111;    // line idles high
            data_sync <= 2'b11;
        end
        else
        begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    assign edge_seen = clk_sync[2] & ~clk_sync[1];
    assign in_frame  = (bit_cnt != 4'd0);

    // word as it looks once the current bit is shifted in
    assign frame_nxt.raw = {data_sync[1], shift_q.raw[FRAME_BITS-1:1]};

    assign frame_ok = (frame_nxt.fld.start == 1'b0) &&
                      (frame_nxt.fld.stop == 1'b1) &&
                      (^{frame_nxt.fld.code, frame_nxt.fld.parity});   // odd parity

    always_ff @(posedge clk)
    begin
        if (edge_seen)
        begin
            shift_q <= frame_nxt;
        end
        if (edge_seen && bit_cnt == 4'(FRAME_BITS - 1))
        begin
            code <= frame_nxt.fld.code;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bit_cnt   <= 4'd0;
            code_wr   <= 1'b0;
            frame_err <= 1'b0;
        end
        else
        begin
            code_wr   <= 1'b0;
            frame_err <= 1'b0;
            if (stall)
            begin
                bit_cnt   <= 4'd0;      // drop the partial frame
                frame_err <= 1'b1;
            end
            else if (edge_seen)
            begin
                if (bit_cnt == 4'(FRAME_BITS - 1))
                begin
                    bit_cnt   <= 4'd0;
                    code_wr   <= frame_ok;
                    frame_err <= ~frame_ok;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ps2_idle_timer.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_idle_timer #(
    parameter int IDLE_CYCLES = 400
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic edge_seen,
    input  wire logic in_frame,
    output logic      stall
);

    localparam int CW = $clog2(IDLE_CYCLES + 1);

    logic [CW-1:0] idle_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idle_cnt <= '0;
            stall    <= 1'b0;
        end
        else
        begin
            stall <= 1'b0;
            if (edge_seen || !in_frame)
            begin
                idle_cnt <= '0;
            end
            else if (idle_cnt != CW'(IDLE_CYCLES))
            begin
                idle_cnt <= idle_cnt + 1'b1;    // saturates at the limit
                stall    <= (idle_cnt == CW'(IDLE_CYCLES - 1));
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ps2_keyboard_top.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard_top
    import ps2_pkg::*;
#(
    parameter int FIFO_AW     = 3,
    parameter int IDLE_CYCLES = 400
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  ps2_clk,
    input  wire logic  ps2_data,
    input  wire logic  key_hold,
    output logic [7:0] key_ascii,
    output logic       key_valid,
    output logic       overflow,
    output logic       frame_err
);

    logic       edge_seen;
    logic       in_frame;
    logic       stall;
    scan_code_t rx_code;
    logic       rx_code_wr;

    scan_if scan_q ();

    ps2_frame_rx ps2_frame_rx_inst (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .stall     (stall),
        .edge_seen (edge_seen),
        .in_frame  (in_frame),
        .code      (rx_code),
        .code_wr   (rx_code_wr),
        .frame_err (frame_err)
    );

    ps2_idle_timer #(
        .IDLE_CYCLES (IDLE_CYCLES)
    ) ps2_idle_timer_inst (
        .clk       (clk),
        .rst       (rst),
        .edge_seen (edge_seen),
        .in_frame  (in_frame),
        .stall     (stall)
    );

    scan_fifo #(
        .FIFO_AW (FIFO_AW)
    ) scan_fifo_inst (
        .clk     (clk),
        .rst     (rst),
        .code    (rx_code),
        .code_wr (rx_code_wr),
        .q       (scan_q.fifo)
    );

    key_decode_fsm key_decode_fsm_inst (
        .clk       (clk),
        .rst       (rst),
        .key_hold  (key_hold),
        .q         (scan_q.dec),
        .key_ascii (key_ascii),
        .key_valid (key_valid)
    );

    assign overflow = scan_q.overflow;

endmodule

`default_nettype wire

//--- source/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    localparam int SCAN_W     = 8;
    localparam int FRAME_BITS = 11;

    typedef logic [SCAN_W-1:0] scan_code_t;

    // one PS/2 frame, bit 0 is the first bit on the wire
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;         // shift register view
        struct packed {
            logic       stop;
            logic       parity;
            scan_code_t code;               // lsb first on the wire
            logic       start;
        } fld;
    } ps2_frame_u;

    localparam scan_code_t SC_BREAK  = 8'hf0;
    localparam scan_code_t SC_LSHIFT = 8'h12;
    localparam scan_code_t SC_RSHIFT = 8'h59;
    localparam scan_code_t SC_EXT    = 8'he0;

endpackage

`default_nettype wire

//--- source/scan_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module scan_fifo
    import ps2_pkg::*;
#(
    parameter int FIFO_AW = 3
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire scan_code_t code,
    input  wire logic       code_wr,
    scan_if.fifo            q
);

    localparam int DEPTH = 2 ** FIFO_AW;

    scan_code_t       mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;      // one extra bit tells full from empty
    logic               full;
    logic               do_wr;
    logic               ovf_q;

    assign full  = (count == (FIFO_AW + 1)'(DEPTH));
    assign do_wr = code_wr && !full;

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= code;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf_q  <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (q.pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (FIFO_AW + 1)'(do_wr) - (FIFO_AW + 1)'(q.pop);
            if (code_wr && full)
                ovf_q <= 1'b1;      // code lost
        end
    end

    assign q.code     = mem[rd_ptr];
    assign q.avail    = (count != '0);
    assign q.overflow = ovf_q;

endmodule

`default_nettype wire

//--- source/scan_if.sv
`timescale 1ns/100ps
`default_nettype none

interface scan_if
    import ps2_pkg::*;
();

    scan_code_t code;       // fifo head, always valid when avail
    logic       avail;
    logic       pop;
    logic       overflow;   // sticky until reset

    modport fifo (output code, output avail, output overflow, input pop);
    modport dec  (input code, input avail, input overflow, output pop);

endinterface

`default_nettype wire

//--- tb/ps2_keyboard_chk.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic key_valid,
    input wire logic overflow,
    input wire logic pop,
    input wire logic avail
);

    int fired = 0;      // failed assertions so far

    valid_in_reset: assert property (@(posedge clk) rst |=> !key_valid)
        else
        begin
            $error("key_valid high during reset");
            fired++;
        end

    overflow_sticky: assert property (@(posedge clk) disable iff (rst) overflow |=> overflow)
        else
        begin
            $error("overflow cleared without reset");
            fired++;
        end

    pop_needs_avail: assert property (@(posedge clk) disable iff (rst) pop |-> avail)
        else
        begin
            $error("pop while fifo empty");
            fired++;
        end

endmodule

bind ps2_keyboard_top ps2_keyboard_chk chk_inst (
    .clk       (clk),
    .rst       (rst),
    .key_valid (key_valid),
    .overflow  (overflow),
    .pop       (scan_q.pop),
    .avail     (scan_q.avail)
);

`default_nettype wire

//--- tb/ps2_keyboard_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard_monitor (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       key_valid,
    input wire logic [7:0] key_ascii,
    input wire logic       frame_err,
    input wire logic       overflow
);

    // scan set 2 make codes, letters in alphabetical order, digits 0 to 9
    localparam logic [7:0] LETTER_SC [26] = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b,
        8'h34, 8'h33, 8'h43, 8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15,
        8'h2d, 8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};
    localparam logic [7:0] DIGIT_SC [10] = '{8'h45, 8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e,
        8'h36, 8'h3d, 8'h3e, 8'h46};

    logic [7:0] expect_q [$];
    logic [7:0] exp_ch;
    string      test_name;
    int         test_errs  = 0;
    int         total_errs = 0;
    int         n_tests    = 0;
    int         ferr_cnt   = 0;

    // expected ascii for a make code, bit 8 low means no output
    function automatic logic [8:0] ref_ascii(input logic [7:0] sc, input logic shift);
        for (int i = 0; i < 26; i++)
            if (sc == LETTER_SC[i])
                return {1'b1, (shift ? 8'h41 : 8'h61) + 8'(i)};
        for (int i = 0; i < 10; i++)
            if (sc == DIGIT_SC[i])
                return {1'b1, 8'h30 + 8'(i)};   // shift has no effect on digits
        return 9'h000;
    endfunction

    function automatic logic [7:0] key_code(input int idx);
        return (idx < 26) ? LETTER_SC[idx] : DIGIT_SC[idx - 26];
    endfunction

    function automatic int pending();
        return expect_q.size();
    endfunction

    function automatic int ferr_seen();
        return ferr_cnt;
    endfunction

    function automatic int errors();
        return total_errs;
    endfunction

    task automatic expect_key(input logic [7:0] sc, input logic shift);
        logic [8:0] r;
        r = ref_ascii(sc, shift);
        if (r[8])
            expect_q.push_back(r[7:0]);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        ferr_cnt  = 0;
        expect_q.delete();
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (exp != act)
        begin
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic end_test(input int exp_ferr, input int exp_ovf);
        if (expect_q.size() != 0)
        begin
            $display("%s: %0d expected key(s) never came out", test_name, expect_q.size());
            test_errs++;
            expect_q.delete();
        end
        check_count("frame_err pulses", exp_ferr, ferr_cnt);
        check_count("overflow", exp_ovf, int'(overflow));
        $display("test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "FAILED",
                 test_errs);
        total_errs += test_errs;
        n_tests++;
    endtask

    task automatic summary();
        $display("%0d tests run, %0d errors", n_tests, total_errs);
    endtask

    // outputs change on the rising edge, sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst && frame_err)
            ferr_cnt++;
        if (!rst && key_valid)
        begin
            if (expect_q.size() == 0)
            begin
                $display("%s: key_valid with no key pending, ascii %h", test_name, key_ascii);
                test_errs++;
            end
            else
            begin
                exp_ch = expect_q.pop_front();
                if (exp_ch != key_ascii)
                begin
                    $display("MISMATCH %s: expected %h, actual %h", test_name, exp_ch,
                             key_ascii);
                    test_errs++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_ps2_keyboard.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ps2_keyboard
    import ps2_pkg::*;
();

    localparam int HALF_CLKS   = 20;                    // system clocks per ps2 half period
    localparam int IDLE_CYCLES = 400;
    localparam int FRAME_CLKS  = 11 * 2 * HALF_CLKS + 2 * HALF_CLKS;   // bits plus gap
    localparam int N_FRAMES    = 120;                   // upper bound on frames over all tests
    localparam int DRAIN_CLKS  = 200;
    localparam int WATCHDOG_NS = (N_FRAMES * FRAME_CLKS + 2 * IDLE_CYCLES + 6 * DRAIN_CLKS)
                                 * 8 * 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic        key_hold;
    logic [7:0]  key_ascii;
    logic        key_valid;
    logic        overflow;
    logic        frame_err;
    logic        shift_held;
    logic [31:0] lfsr_q = 32'h91b7;
    logic [7:0]  sc;

    always #4 clk = ~clk;

    ps2_keyboard_top #(
        .FIFO_AW     (3),
        .IDLE_CYCLES (IDLE_CYCLES)
    ) ps2_keyboard_top_inst (
        .clk       (clk),
        .rst       (rst),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .key_hold  (key_hold),
        .key_ascii (key_ascii),
        .key_valid (key_valid),
        .overflow  (overflow),
        .frame_err (frame_err)
    );

    ps2_keyboard_monitor mon_inst (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_ascii (key_ascii),
        .frame_err (frame_err),
        .overflow  (overflow)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic rand_key(output logic [7:0] code);
        logic [31:0] v;
        rand_bits(6, v);
        code = mon_inst.key_code(int'(v % 32'd36));     // 26 letters then 10 digits
    endtask

    task automatic send_bit(input logic b);
        ps2_data = b;                   // set up while ps2_clk is high
        repeat (HALF_CLKS) @(negedge clk);
        ps2_clk = 1'b0;
        repeat (HALF_CLKS) @(negedge clk);
        ps2_clk = 1'b1;
    endtask

    task automatic send_frame(input logic [7:0] code, input logic bad_par, input logic bad_stop,
                              input int n_bits);
        logic [10:0] w;
        w = {~bad_stop, (~^code) ^ bad_par, code, 1'b0};   // odd parity when good
        for (int i = 0; i < n_bits; i++)
            send_bit(w[i]);
        ps2_data = 1'b1;
        repeat (2 * HALF_CLKS) @(negedge clk);
    endtask

    task automatic send_code(input logic [7:0] code);
        send_frame(code, 1'b0, 1'b0, 11);
    endtask

    // make then break with the expected output queued first
    task automatic press(input logic [7:0] code);
        mon_inst.expect_key(code, shift_held);
        send_code(code);
        send_code(SC_BREAK);
        send_code(code);
    endtask

    task automatic wait_keys();
        int n;
        n = 0;
        while (mon_inst.pending() != 0 && n < DRAIN_CLKS)
        begin
            @(negedge clk);
            n++;
        end
        repeat (8) @(negedge clk);      // window for stray outputs
    endtask

    task automatic wait_ferr(input int cnt, input int limit);
        int n;
        n = 0;
        while (mon_inst.ferr_seen() < cnt && n < limit)
        begin
            @(negedge clk);
            n++;
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        rst        = 1'b1;
        ps2_clk    = 1'b1;
        ps2_data   = 1'b1;
        key_hold   = 1'b0;
        shift_held = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        mon_inst.start_test("random");
        repeat (12)
        begin
            rand_key(sc);
            press(sc);
        end
        wait_keys();
        mon_inst.end_test(0, 0);

        mon_inst.start_test("shift");
        send_code(SC_LSHIFT);
        shift_held = 1'b1;
        press(8'h1c);
        repeat (6)
        begin
            rand_key(sc);
            press(sc);
        end
        send_code(SC_BREAK);
        send_code(SC_LSHIFT);
        shift_held = 1'b0;
        press(8'h1c);
        repeat (4)
        begin
            rand_key(sc);
            press(sc);
        end
        send_code(SC_RSHIFT);
        shift_held = 1'b1;
        press(8'h32);
        send_code(SC_BREAK);
        send_code(SC_RSHIFT);
        shift_held = 1'b0;
        press(8'h32);
        wait_keys();
        mon_inst.end_test(0, 0);

        mon_inst.start_test("break_ext");
        send_code(SC_BREAK);
        send_code(8'h1c);
        send_code(SC_EXT);
        send_code(8'h34);       // media key, same low byte as g
        send_code(SC_EXT);
        send_code(SC_BREAK);
        send_code(8'h34);
        press(8'h32);
        wait_keys();
        mon_inst.end_test(0, 0);

        mon_inst.start_test("bad_frame");
        send_frame(8'h1c, 1'b1, 1'b0, 11);
        send_frame(8'h1c, 1'b0, 1'b1, 11);
        press(8'h4d);
        wait_keys();
        mon_inst.end_test(2, 0);

        mon_inst.start_test("stall");
        send_frame(8'h1c, 1'b0, 1'b0, 5);
        wait_ferr(1, IDLE_CYCLES + 100);
        press(8'h45);
        wait_keys();
        mon_inst.end_test(1, 0);

        mon_inst.start_test("overflow");
        key_hold = 1'b1;
        for (int i = 0; i < 10; i++)
        begin
            if (i < 8)
                mon_inst.expect_key(mon_inst.key_code(i), shift_held);
            send_code(mon_inst.key_code(i));
        end
        key_hold = 1'b0;
        wait_keys();
        mon_inst.end_test(0, 1);

        mon_inst.summary();
        if (mon_inst.errors() == 0 && ps2_keyboard_top_inst.chk_inst.fired == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
